/* Makefile */
# Verilator build for the exception subsystem.

VERILATOR ?= verilator
FILELIST  ?= mango_exc.f
RTL_TOP   ?= exc_subsys_top
TB_TOP    ?= exc_subsys_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR) -o V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "no result in log"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* mango_exc.f */
+incdir+test
source/mango_exc_pkg.sv
source/fetch_fault_check.sv
source/decode_fault_check.sv
source/pipe_stage_reg.sv
source/exception_resolver.sv
source/cp0_exception_regs.sv
source/exc_subsys_top.sv
test/exc_subsys_tb.sv

/* source/cp0_exception_regs.sv */
/*
 * CP0 exception registers: EPC, BadVAddr, Cause.ExcCode, Status.EXL.
 * Commits the resolved cause, raises flush and the redirect.
 */

module cp0_exception_regs #(
    parameter int ADDR_W = 32
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  stall,
    input  mango_exc_pkg::resolved_exc_t          resolved,
    output logic                                  exc_taken,
    output logic                                  redirect,
    output logic                     [ADDR_W-1:0] redirect_pc,
    output logic                                  flush,
    output mango_exc_pkg::exc_code_t              exc_code,
    output logic                     [ADDR_W-1:0] epc,
    output logic                     [ADDR_W-1:0] badvaddr,
    output logic                                  exl
);

    logic              take;
    logic              ret;
    logic [ADDR_W-1:0] handler;

    assign take  = resolved.flag & ~stall;
    assign ret   = resolved.is_eret & ~stall;
    assign flush = take | ret;          // Drops the two younger instructions.

    // Nested exceptions always use the general vector.
    assign handler = (resolved.refill && !exl) ?
                     mango_exc_pkg::vec_base + mango_exc_pkg::vec_refill_off :
                     mango_exc_pkg::vec_base + mango_exc_pkg::vec_general_off;

    // ----------------------------------------------------------------------
    // Commit
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exc_taken <= 1'b0;
            redirect  <= 1'b0;
            exl       <= 1'b0;
            exc_code  <= mango_exc_pkg::exc_int;
            epc       <= '0;
            badvaddr  <= '0;
        end else begin
            exc_taken <= take;
            redirect  <= take | ret;
            if (take) begin
                exc_code <= resolved.code;
                exl      <= 1'b1;
                if (!exl) begin
                    epc <= resolved.pc;     // Keep the outer return point.
                end
                if (resolved.use_badaddr) begin
                    badvaddr <= resolved.badaddr;
                end
            end else if (ret) begin
                exl <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            redirect_pc <= handler;
        end else if (ret) begin
            redirect_pc <= epc;
        end
    end

    // The resolver never hands over a cause and an ERET at once.
    no_take_with_eret: assert property (@(posedge clk) disable iff (!rst_n)
        !(resolved.flag && resolved.is_eret));

endmodule

/* source/decode_fault_check.sv */
/*
 * Decode-stage fault check.
 * Classifies opcode/funct into sys, bp, eret, cpu and ri,
 * flags loads and stores, and forms the id_ex_t payload.
 */

module decode_fault_check #(
    parameter int ADDR_W = 32
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              valid,
    input  logic                       [31:0] instr,
    input  logic                              cu0_usable,
    input  mango_exc_pkg::fault_vec_t         fetch_faults,
    input  logic                 [ADDR_W-1:0] pc,
    output mango_exc_pkg::id_ex_t             payload
);

    mango_exc_pkg::fault_vec_t if_faults;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rs;
    logic       fetch_bad;
    logic       dec_sys, dec_bp, dec_eret, dec_cpu, dec_ri;
    logic       dec_mem, dec_store;

    fetch_fault_check #(
        .ADDR_W (ADDR_W)
    ) fetch_chk (
        .pc     (pc),
        .tlbr   (fetch_faults.if_tlbr),
        .tlbi   (fetch_faults.if_tlbi),
        .buserr (fetch_faults.ibe),
        .faults (if_faults)
    );

    assign opcode    = instr[31:26];
    assign rs        = instr[25:21];
    assign funct     = instr[5:0];
    assign fetch_bad = if_faults.if_ade | if_faults.if_tlbr | if_faults.if_tlbi | if_faults.ibe;

    always_comb begin
        dec_sys   = 1'b0;
        dec_bp    = 1'b0;
        dec_eret  = 1'b0;
        dec_cpu   = 1'b0;
        dec_ri    = 1'b0;
        dec_mem   = 1'b0;
        dec_store = 1'b0;
        case (opcode)
            6'h00: begin
                case (funct)
                    6'h0c: dec_sys = 1'b1;
                    6'h0d: dec_bp  = 1'b1;
                    6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09,
                    6'h10, 6'h11, 6'h12, 6'h13, 6'h18, 6'h19, 6'h1a, 6'h1b,
                    6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
                    6'h2a, 6'h2b, 6'h30, 6'h31, 6'h32, 6'h33, 6'h34, 6'h36: begin
                    end
                    default: dec_ri = 1'b1;
                endcase
            end
            6'h01, 6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07,
            6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
            end
            6'h10: begin
                if (!cu0_usable)
                    dec_cpu = 1'b1;
                else if (instr[25] && funct == 6'h18)
                    dec_eret = 1'b1;
                else if (rs != 5'h00 && rs != 5'h04)
                    dec_ri = 1'b1;      // Only mfc0/mtc0 otherwise.
            end
            6'h11, 6'h12, 6'h13: dec_cpu = 1'b1;
            6'h20, 6'h21, 6'h23, 6'h24, 6'h25: dec_mem = 1'b1;
            6'h28, 6'h29, 6'h2b: begin
                dec_mem   = 1'b1;
                dec_store = 1'b1;
            end
            default: dec_ri = 1'b1;
        endcase
    end

    // A faulted fetch leaves no real instruction word to decode.
    always_comb begin
        payload             = '0;
        payload.pc          = pc;
        payload.faults      = if_faults;
        payload.faults.sys  = dec_sys & ~fetch_bad;
        payload.faults.bp   = dec_bp & ~fetch_bad;
        payload.faults.eret = dec_eret & ~fetch_bad;
        payload.faults.cpu  = dec_cpu & ~fetch_bad;
        payload.faults.ri   = dec_ri & ~fetch_bad;
        payload.is_mem      = dec_mem & ~fetch_bad;
        payload.is_store    = dec_store & ~fetch_bad;
    end

    // A valid instruction arrives with a known word and pc.
    known_when_valid: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> !$isunknown({instr, pc}));

endmodule

/* source/exc_subsys_top.sv */
/*
 * Exception subsystem top.
 * Decode checker, ID/EX and EX/MEM stage registers,
 * resolver and CP0 exception registers.
 */

module exc_subsys_top #(
    parameter int ADDR_W = 32
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  id_valid,
    input  logic                     [ADDR_W-1:0] id_pc,
    input  logic                           [31:0] id_instr,
    input  logic                                  if_tlbr,
    input  logic                                  if_tlbi,
    input  logic                                  if_buserr,
    input  logic                                  cu0_usable,
    input  logic                                  ex_ov,
    input  logic                                  ex_trap,
    input  logic                                  m_en,
    input  logic                                  m_store,
    input  logic                     [ADDR_W-1:0] m_vaddr,
    input  logic                                  d_tlbr,
    input  logic                                  d_tlbi,
    input  logic                                  d_tlbm,
    input  logic                                  d_buserr,
    input  logic                                  intr_pending,
    input  logic                                  stall,
    output logic                                  exc_taken,
    output logic                                  redirect,
    output logic                     [ADDR_W-1:0] redirect_pc,
    output mango_exc_pkg::exc_code_t              exc_code,
    output logic                     [ADDR_W-1:0] epc,
    output logic                     [ADDR_W-1:0] badvaddr,
    output logic                                  exl
);

    mango_exc_pkg::fault_vec_t    fetch_raw;
    mango_exc_pkg::id_ex_t        id_payload;
    mango_exc_pkg::id_ex_t        ex_payload;
    mango_exc_pkg::ex_mem_t       ex_mem_in;
    mango_exc_pkg::ex_mem_t       mem_payload;
    mango_exc_pkg::resolved_exc_t resolved;
    logic ex_valid, mem_valid, flush;

    assign fetch_raw = '{if_tlbr: if_tlbr, if_tlbi: if_tlbi, ibe: if_buserr, default: 1'b0};

    decode_fault_check #(
        .ADDR_W (ADDR_W)
    ) dec_chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid        (id_valid),
        .instr        (id_instr),
        .cu0_usable   (cu0_usable),
        .fetch_faults (fetch_raw),
        .pc           (id_pc),
        .payload      (id_payload)
    );

    pipe_stage_reg #(
        .payload_t (mango_exc_pkg::id_ex_t)
    ) id_ex_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .flush     (flush),
        .in_valid  (id_valid),
        .in_data   (id_payload),
        .out_valid (ex_valid),
        .out_data  (ex_payload)
    );

    // Execute-stage faults join here.
    always_comb begin
        ex_mem_in.pc          = ex_payload.pc;
        ex_mem_in.faults      = ex_payload.faults;
        ex_mem_in.faults.ov   = ex_ov;
        ex_mem_in.faults.trap = ex_trap;
        ex_mem_in.is_mem      = ex_payload.is_mem;
        ex_mem_in.is_store    = ex_payload.is_store;
    end

    pipe_stage_reg #(
        .payload_t (mango_exc_pkg::ex_mem_t)
    ) ex_mem_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .flush     (flush),
        .in_valid  (ex_valid),
        .in_data   (ex_mem_in),
        .out_valid (mem_valid),
        .out_data  (mem_payload)
    );

    exception_resolver #(
        .ADDR_W (ADDR_W)
    ) resolver (
        .valid        (mem_valid),
        .stage        (mem_payload),
        .m_en         (m_en),
        .m_store      (m_store),
        .m_vaddr      (m_vaddr),
        .d_tlbr       (d_tlbr),
        .d_tlbi       (d_tlbi),
        .d_tlbm       (d_tlbm),
        .d_buserr     (d_buserr),
        .intr_pending (intr_pending),
        .resolved     (resolved)
    );

    cp0_exception_regs #(
        .ADDR_W (ADDR_W)
    ) cp0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .resolved    (resolved),
        .exc_taken   (exc_taken),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .flush       (flush),
        .exc_code    (exc_code),
        .epc         (epc),
        .badvaddr    (badvaddr),
        .exl         (exl)
    );

endmodule

/* source/exception_resolver.sv */
/*
 * Memory-stage exception resolver.
 * Merges interrupt and data-side faults, picks the highest
 * priority cause and selects the bad address.
 */

module exception_resolver #(
    parameter int ADDR_W = 32
) (
    input  logic                                  valid,
    input  mango_exc_pkg::ex_mem_t                stage,
    input  logic                                  m_en,
    input  logic                                  m_store,
    input  logic                     [ADDR_W-1:0] m_vaddr,
    input  logic                                  d_tlbr,
    input  logic                                  d_tlbi,
    input  logic                                  d_tlbm,
    input  logic                                  d_buserr,
    input  logic                                  intr_pending,
    output mango_exc_pkg::resolved_exc_t          resolved
);

    mango_exc_pkg::fault_vec_t f;
    mango_exc_pkg::exc_code_t  code;
    logic use_pc, use_va;

    always_comb begin
        f = '0;
        if (valid) begin
            f        = stage.faults;
            f.intr   = intr_pending & ~m_en;    // Not in the middle of an access.
            f.d_ade  = m_en & (m_vaddr[1:0] != 2'b00);
            f.d_tlbr = d_tlbr;
            f.d_tlbi = d_tlbi;
            f.d_tlbm = d_tlbm;
            f.dbe    = d_buserr;
        end
    end

    // ----------------------------------------------------------------------
    // Priority pick
    // ----------------------------------------------------------------------
    always_comb begin
        code   = mango_exc_pkg::exc_none;
        use_pc = 1'b0;
        use_va = 1'b0;
        if (f.intr) begin
            code = mango_exc_pkg::exc_int;
        end else if (f.if_ade) begin
            code   = mango_exc_pkg::exc_adel;
            use_pc = 1'b1;
        end else if (f.if_tlbr || f.if_tlbi) begin
            code   = mango_exc_pkg::exc_tlbl;
            use_pc = 1'b1;
        end else if (f.ibe) begin
            code = mango_exc_pkg::exc_ibe;
        end else if (f.cpu) begin
            code = mango_exc_pkg::exc_cpu;
        end else if (f.ri) begin
            code = mango_exc_pkg::exc_ri;
        end else if (f.ov) begin
            code = mango_exc_pkg::exc_ov;
        end else if (f.trap) begin
            code = mango_exc_pkg::exc_tr;
        end else if (f.sys) begin
            code = mango_exc_pkg::exc_sys;
        end else if (f.bp) begin
            code = mango_exc_pkg::exc_bp;
        end else if (f.d_ade) begin
            code   = m_store ? mango_exc_pkg::exc_ades : mango_exc_pkg::exc_adel;
            use_va = 1'b1;
        end else if (f.d_tlbr || f.d_tlbi) begin
            code   = m_store ? mango_exc_pkg::exc_tlbs : mango_exc_pkg::exc_tlbl;
            use_va = 1'b1;
        end else if (f.d_tlbm) begin
            code   = mango_exc_pkg::exc_mod;
            use_va = 1'b1;
        end else if (f.dbe) begin
            code = mango_exc_pkg::exc_dbe;
        end
    end

    always_comb begin
        resolved             = '0;
        resolved.code        = code;
        resolved.flag        = (code != mango_exc_pkg::exc_none);
        resolved.is_eret     = f.eret & ~resolved.flag;
        resolved.use_badaddr = use_pc | use_va;
        resolved.badaddr     = use_va ? m_vaddr : stage.pc;
        resolved.pc          = stage.pc;
        // Refill vector only for the two TLBR causes that won.
        resolved.refill      = (use_pc & f.if_tlbr & ~f.if_ade) |
                               (use_va & f.d_tlbr & ~f.d_ade);
    end

endmodule

/* source/fetch_fault_check.sv */
/*
 * Fetch-side fault bits.
 * Address error on a misaligned pc; TLB and bus flags
 * only count when the fetch was actually issued.
 */

module fetch_fault_check #(
    parameter int ADDR_W = 32
) (
    input  logic                     [ADDR_W-1:0] pc,
    input  logic                                  tlbr,
    input  logic                                  tlbi,
    input  logic                                  buserr,
    output mango_exc_pkg::fault_vec_t             faults
);

    logic aligned;

    assign aligned = (pc[1:0] == 2'b00);

    always_comb begin
        faults         = '0;
        faults.if_ade  = ~aligned;
        faults.if_tlbr = aligned & tlbr;
        faults.if_tlbi = aligned & tlbi;
        faults.ibe     = aligned & buserr;   // No bus cycle otherwise.
    end

    // The instruction TLB reports a refill or an invalid entry, not both.
    always_comb begin
        assert (!(tlbr && tlbi))
            else $error("fetch TLB reports refill and invalid together");
    end

endmodule

/* source/mango_exc_pkg.sv */
/*
 * Shared types for the precise-exception path.
 * Fault vector in priority order, MIPS ExcCode values,
 * stage payload structs, resolved cause and handler vectors.
 */

package mango_exc_pkg;

    // ----------------------------------------------------------------------
    // Fault flags, highest priority first
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic intr;
        logic if_ade;   // Fetch address error.
        logic if_tlbr;
        logic if_tlbi;
        logic ibe;
        logic cpu;
        logic ri;
        logic ov;
        logic trap;
        logic sys;
        logic bp;
        logic d_ade;
        logic d_tlbr;
        logic d_tlbi;
        logic d_tlbm;
        logic dbe;
        logic eret;     // Lowest, never reaches Cause.
    } fault_vec_t;

    typedef enum logic [4:0] {
        exc_int  = 5'd0,
        exc_mod  = 5'd1,
        exc_tlbl = 5'd2,
        exc_tlbs = 5'd3,
        exc_adel = 5'd4,
        exc_ades = 5'd5,
        exc_ibe  = 5'd6,
        exc_dbe  = 5'd7,
        exc_sys  = 5'd8,
        exc_bp   = 5'd9,
        exc_ri   = 5'd10,
        exc_cpu  = 5'd11,
        exc_ov   = 5'd12,
        exc_tr   = 5'd13,
        exc_none = 5'd31    // Internal only.
    } exc_code_t;

    // ----------------------------------------------------------------------
    // Stage payloads
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [31:0] pc;
        fault_vec_t  faults;
        logic        is_mem;
        logic        is_store;
    } id_ex_t;

    typedef struct packed {
        logic [31:0] pc;
        fault_vec_t  faults;    // Ov and trap merged in.
        logic        is_mem;
        logic        is_store;
    } ex_mem_t;

    typedef struct packed {
        logic        flag;
        exc_code_t   code;
        logic        is_eret;
        logic        use_badaddr;
        logic [31:0] badaddr;
        logic        refill;
        logic [31:0] pc;
    } resolved_exc_t;

    localparam logic [31:0] vec_base        = 32'h8000_0000;
    localparam logic [31:0] vec_refill_off  = 32'h0000_0000;
    localparam logic [31:0] vec_general_off = 32'h0000_0180;

endpackage

/* source/pipe_stage_reg.sv */
/*
 * Pipeline stage register for any payload type.
 * Holds on stall; flush and reset drop the valid bit.
 */

module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;      // Flush wins over stall.
        end else if (!stall) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            out_data <= in_data;
        end
    end

    // A valid payload is fully known when it is captured.
    known_on_capture: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && !stall) |-> !$isunknown(in_data));

endmodule

/* test/exc_ref_model.svh */
/*
 * Reference model for the exception path.
 * Issued-instruction record, fault vector build, cause priority,
 * ExcCode, bad address, refill choice and handler address.
 */

`ifndef EXC_REF_MODEL_SVH
`define EXC_REF_MODEL_SVH

typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    logic        cu0;
    logic        if_tlbr;
    logic        if_tlbi;
    logic        if_buserr;
    logic        ex_ov;
    logic        ex_trap;
    logic        m_en;
    logic        m_store;
    logic [31:0] m_vaddr;
    logic        d_tlbr;
    logic        d_tlbi;
    logic        d_tlbm;
    logic        d_buserr;
    logic        intr;
    logic [31:0] issue_cyc;
} instr_rec_t;

function automatic mango_exc_pkg::fault_vec_t expected_faults(instr_rec_t r);
    mango_exc_pkg::fault_vec_t f;
    logic [5:0] op;
    logic [5:0] fn;
    f  = '0;
    op = r.instr[31:26];
    fn = r.instr[5:0];
    f.if_ade  = (r.pc[1:0] != 2'b00);
    f.if_tlbr = !f.if_ade && r.if_tlbr;
    f.if_tlbi = !f.if_ade && r.if_tlbi;
    f.ibe     = !f.if_ade && r.if_buserr;
    if (!(f.if_ade || f.if_tlbr || f.if_tlbi || f.ibe)) begin
        f.sys  = (op == 6'h00) && (fn == 6'h0c);
        f.bp   = (op == 6'h00) && (fn == 6'h0d);
        f.cpu  = (op == 6'h10 && !r.cu0) || (op == 6'h11);
        f.ri   = (op == 6'h3f);
        f.eret = (op == 6'h10) && r.cu0 && r.instr[25] && (fn == 6'h18);
    end
    f.ov     = r.ex_ov;
    f.trap   = r.ex_trap;
    f.intr   = r.intr && !r.m_en;      // Masked during an access.
    f.d_ade  = r.m_en && (r.m_vaddr[1:0] != 2'b00);
    f.d_tlbr = r.d_tlbr;
    f.d_tlbi = r.d_tlbi;
    f.d_tlbm = r.d_tlbm;
    f.dbe    = r.d_buserr;
    return f;
endfunction

function automatic mango_exc_pkg::exc_code_t cause_code(mango_exc_pkg::fault_vec_t f,
                                                         logic store);
    if (f.intr)                 return mango_exc_pkg::exc_int;
    if (f.if_ade)               return mango_exc_pkg::exc_adel;
    if (f.if_tlbr || f.if_tlbi) return mango_exc_pkg::exc_tlbl;
    if (f.ibe)                  return mango_exc_pkg::exc_ibe;
    if (f.cpu)                  return mango_exc_pkg::exc_cpu;
    if (f.ri)                   return mango_exc_pkg::exc_ri;
    if (f.ov)                   return mango_exc_pkg::exc_ov;
    if (f.trap)                 return mango_exc_pkg::exc_tr;
    if (f.sys)                  return mango_exc_pkg::exc_sys;
    if (f.bp)                   return mango_exc_pkg::exc_bp;
    if (f.d_ade)  return store ? mango_exc_pkg::exc_ades : mango_exc_pkg::exc_adel;
    if (f.d_tlbr || f.d_tlbi)
        return store ? mango_exc_pkg::exc_tlbs : mango_exc_pkg::exc_tlbl;
    if (f.d_tlbm)               return mango_exc_pkg::exc_mod;
    if (f.dbe)                  return mango_exc_pkg::exc_dbe;
    return mango_exc_pkg::exc_none;
endfunction

// Fetch address causes report the pc, data address causes the vaddr.
function automatic logic [31:0] bad_address(mango_exc_pkg::fault_vec_t f, instr_rec_t r,
                                            logic [31:0] old);
    if (f.intr) return old;
    if (f.if_ade || f.if_tlbr || f.if_tlbi) return r.pc;
    if (f.ibe || f.cpu || f.ri || f.ov || f.trap || f.sys || f.bp) return old;
    if (f.d_ade || f.d_tlbr || f.d_tlbi || f.d_tlbm) return r.m_vaddr;
    return old;
endfunction

function automatic logic refill_wins(mango_exc_pkg::fault_vec_t f);
    if (f.intr || f.if_ade) return 1'b0;
    if (f.if_tlbr || f.if_tlbi) return f.if_tlbr;
    if (f.ibe || f.cpu || f.ri || f.ov || f.trap || f.sys || f.bp || f.d_ade) return 1'b0;
    return f.d_tlbr;
endfunction

function automatic logic [31:0] handler_address(logic refill, logic exl_now);
    return (refill && !exl_now) ? 32'h8000_0000 : 32'h8000_0180;
endfunction

`endif

/* test/exc_subsys_tb.sv */
/*
 * Testbench for the exception subsystem.
 * Directed and random instruction stream, comparison process
 * against the reference model, per-test report.
 */

module exc_subsys_tb;

    `include "exc_ref_model.svh"

    localparam logic [31:0] op_nop  = 32'h0000_0000;
    localparam logic [31:0] op_sys  = 32'h0000_000c;
    localparam logic [31:0] op_bp   = 32'h0000_000d;
    localparam logic [31:0] op_eret = 32'h4200_0018;
    localparam logic [31:0] op_cop1 = 32'h4400_0000;
    localparam logic [31:0] op_ri   = 32'hfc00_0000;

    logic clk, rst_n, id_valid, stall, cu0_usable;
    logic if_tlbr, if_tlbi, if_buserr, ex_ov, ex_trap, intr_pending;
    logic m_en, m_store, d_tlbr, d_tlbi, d_tlbm, d_buserr;
    logic [31:0] id_pc, id_instr, m_vaddr;
    logic exc_taken, redirect, exl;
    logic [31:0] redirect_pc, epc, badvaddr;
    mango_exc_pkg::exc_code_t exc_code;

    instr_rec_t  exp_q[$];
    instr_rec_t  cmp_rec;
    mango_exc_pkg::fault_vec_t cmp_f;
    mango_exc_pkg::exc_code_t  cmp_code;
    logic [31:0] cyc;
    logic [31:0] model_epc, model_bad;
    logic        model_exl;
    integer      seed = 32'h2d;
    int          checks, errors, test_errs, tests;

    exc_subsys_top #(.ADDR_W(32)) dut0 (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errs++;
            $display("** Error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("%-14s %s (%0d errors)", name, (test_errs == 0) ? "ok" : "failed", test_errs);
        test_errs = 0;
    endtask

    function automatic instr_rec_t make_rec(logic [31:0] pc, logic [31:0] instr);
        instr_rec_t r;
        r         = '0;
        r.pc      = pc;
        r.instr   = instr;
        r.cu0     = 1'b1;
        r.m_vaddr = 32'h1000_0000;
        return r;
    endfunction

    task automatic drive_rec(input instr_rec_t r);
        id_pc        <= r.pc;
        id_instr     <= r.instr;
        cu0_usable   <= r.cu0;
        if_tlbr      <= r.if_tlbr;
        if_tlbi      <= r.if_tlbi;
        if_buserr    <= r.if_buserr;
        ex_ov        <= r.ex_ov;
        ex_trap      <= r.ex_trap;
        m_en         <= r.m_en;
        m_store      <= r.m_store;
        m_vaddr      <= r.m_vaddr;
        d_tlbr       <= r.d_tlbr;
        d_tlbi       <= r.d_tlbi;
        d_tlbm       <= r.d_tlbm;
        d_buserr     <= r.d_buserr;
        intr_pending <= r.intr;
    endtask

    task automatic wait_drain();
        for (int n = 0; n < 50 && exp_q.size() != 0; n++) begin
            @(posedge clk);
        end
        if (exp_q.size() != 0) begin
            $display("timeout: expected exception pulse did not arrive within 50 cycles");
            $display(">>> FAIL");
            $finish;
        end
    endtask

    // One instruction through the pipe, late flags held until it drains.
    task automatic run_instr(input instr_rec_t r, input int stall_n);
        mango_exc_pkg::fault_vec_t f;
        logic pulse;
        f     = expected_faults(r);
        pulse = (cause_code(f, r.m_store) != mango_exc_pkg::exc_none) || f.eret;
        @(posedge clk);
        drive_rec(r);
        id_valid    <= 1'b1;
        r.issue_cyc = cyc + 1 + stall_n;    // Stall cycles push the pulse back.
        if (pulse)
            exp_q.push_back(r);
        @(posedge clk);
        id_valid <= 1'b0;
        if (stall_n > 0) begin
            stall <= 1'b1;
            repeat (stall_n) @(posedge clk);
            stall <= 1'b0;
        end
        if (pulse)
            wait_drain();
        else
            repeat (4) @(posedge clk);
        drive_rec(make_rec(32'h0, op_nop));
    endtask

    // ----------------------------------------------------------------------
    // Comparison process
    // ----------------------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n && (exc_taken || redirect)) begin
            if (exp_q.size() == 0) begin
                errors++;
                test_errs++;
                $display("pulse seen with no instruction expecting one");
            end else begin
                cmp_rec  = exp_q.pop_front();
                cmp_f    = expected_faults(cmp_rec);
                cmp_code = cause_code(cmp_f, cmp_rec.m_store);
                check_val("redirect", redirect, 1);
                if (cmp_code != mango_exc_pkg::exc_none) begin
                    check_val("exc_taken", exc_taken, 1);
                    check_val("exc_code", exc_code, cmp_code);
                    check_val("epc", epc, model_exl ? model_epc : cmp_rec.pc);
                    check_val("badvaddr", badvaddr, bad_address(cmp_f, cmp_rec, model_bad));
                    check_val("redirect_pc", redirect_pc,
                              handler_address(refill_wins(cmp_f), model_exl));
                    check_val("exl", exl, 1);
                    if (!model_exl)
                        model_epc = cmp_rec.pc;
                    model_bad = bad_address(cmp_f, cmp_rec, model_bad);
                    model_exl = 1'b1;
                end else begin
                    check_val("exc_taken", exc_taken, 0);
                    check_val("redirect_pc", redirect_pc, model_epc);
                    check_val("exl", exl, 0);
                    model_exl = 1'b0;
                end
                check_val("pulse latency", cyc - cmp_rec.issue_cyc, 3);
            end
        end
    end

    initial begin
        instr_rec_t r;
        logic [31:0] v, w, x;
        logic [31:0] pool [8];
        clk = 0;
        rst_n = 0;
        cyc = 0;
        id_valid = 0;
        stall = 0;
        drive_rec(make_rec(32'h0, op_nop));
        model_epc = 0;
        model_bad = 0;
        model_exl = 0;
        pool = '{op_nop, op_sys, op_bp, op_eret, op_cop1, op_ri, op_nop, op_eret};
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_val("exc_taken", exc_taken, 0);
        check_val("redirect", redirect, 0);
        check_val("exl", exl, 0);
        for (int i = 0; i < 5; i++)
            run_instr(make_rec(32'h0040_0000 + 4 * i, op_nop), 0);
        end_test("reset");

        for (int i = 0; i < 16; i++) begin
            run_instr(make_rec(32'h0, op_eret), 0);        // EXL back to 0.
            r = make_rec(32'h0040_1000 + 16 * i, op_nop);
            r.m_vaddr = 32'h1000_0000 + 64 * i;
            case (i)
                0:  r.intr = 1;
                1:  r.pc[1] = 1;
                2:  r.if_tlbr = 1;
                3:  r.if_tlbi = 1;
                4:  r.if_buserr = 1;
                5:  r.instr = op_cop1;
                6:  r.instr = op_ri;
                7:  r.ex_ov = 1;
                8:  r.ex_trap = 1;
                9:  r.instr = op_sys;
                10: r.instr = op_bp;
                11: begin r.m_en = 1; r.m_vaddr[0] = 1; end
                12: begin r.m_en = 1; r.d_tlbr = 1; end
                13: begin r.m_en = 1; r.d_tlbi = 1; end
                14: begin r.m_en = 1; r.d_tlbm = 1; end
                default: r.d_buserr = 1;
            endcase
            run_instr(r, 0);
        end
        end_test("single cause");

        for (int i = 0; i < 40; i++) begin
            v = $random(seed);
            w = $random(seed);
            x = $random(seed);
            r = make_rec({v[31:2], (v[5:3] == 0) ? v[1:0] : 2'b00}, pool[w[2:0]]);
            r.cu0       = w[3] | w[4];
            r.if_tlbr   = &w[7:5];
            r.if_tlbi   = !r.if_tlbr && (&w[10:8]);
            r.if_buserr = &w[13:11];
            r.ex_ov     = &w[16:14];
            r.ex_trap   = &w[19:17];
            r.intr      = &w[22:20];
            r.m_en      = w[23];
            r.m_store   = w[24];
            r.d_tlbr    = &w[27:25];
            r.d_tlbi    = &w[30:28];
            r.d_tlbm    = &x[2:0];
            r.d_buserr  = &x[5:3];
            r.m_vaddr   = {x[31:2], x[6] ? 2'b00 : x[1:0]};
            run_instr(r, 0);
        end
        end_test("random");

        r = make_rec(32'h0040_2000, op_nop);
        r.intr = 1;
        r.m_en = 1;
        run_instr(r, 0);                    // No pulse expected.
        r.intr = 0;
        r.m_store = 1;
        r.m_vaddr = 32'h1000_0102;
        run_instr(r, 0);
        r.m_vaddr = 32'h1000_0200;
        r.d_tlbi = 1;
        run_instr(r, 0);
        end_test("intr and store");

        run_instr(make_rec(32'h0, op_eret), 0);
        run_instr(make_rec(32'h0040_3000, op_sys), 0);
        r = make_rec(32'h0040_3004, op_nop);
        r.if_tlbr = 1;
        run_instr(r, 0);                    // Nested, general vector.
        run_instr(make_rec(32'h0, op_eret), 0);
        end_test("nested eret");

        run_instr(make_rec(32'h0040_4000, op_ri), 5);
        r = make_rec(32'h0040_4100, op_sys);
        @(posedge clk);
        drive_rec(r);
        id_valid    <= 1'b1;
        r.issue_cyc = cyc + 1;
        exp_q.push_back(r);
        @(posedge clk);
        id_pc    <= 32'h0040_4104;
        id_instr <= op_bp;
        @(posedge clk);
        id_pc    <= 32'h0040_4108;
        @(posedge clk);
        id_valid <= 1'b0;
        wait_drain();
        repeat (10) @(posedge clk);
        end_test("stall flush");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule
